//--- corr_pkg.sv
/*
 * Shared definitions for the intensity correlator.
 * Holds the combine opcode and the fixed width constants; modules refer
 * to them by scoped name.
 */
package corr_pkg;

	// how the newest and the lagged sample are combined
	typedef enum logic {
		CORR_MULTIPLY = 1'b0,	// unsigned product
		CORR_SUBTRACT = 1'b1	// newest minus lagged, signed
	} corr_op_e;

	localparam int SAMPLE_W_MAX = 16;	// widest sample the terms are sized for
	localparam int ADDR_W = 8;	// readout baseline and lag index width

endpackage

//--- sample_delay_line.sv
/*
 * Per-channel sample history.
 * Shifts a new sample into tap 0 on each strobe and exposes all taps,
 * newest first. shift_o pulses in the cycle after the taps change.
 */
`timescale 1ns/1ps

module sample_delay_line #(
	parameter int NUM_LAGS = 3,
	parameter int SAMPLE_W = 4
) (
	input  logic                         clk,
	input  logic                         rst_n_i,
	input  logic [SAMPLE_W-1:0]          sample_i,
	input  logic                         stb_i,
	output logic [NUM_LAGS*SAMPLE_W-1:0] taps_o,
	output logic                         shift_o
);

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			taps_o <= '0;
		end else if (stb_i) begin
			taps_o[SAMPLE_W-1:0] <= sample_i;	// newest
			for (int t = 1; t < NUM_LAGS; t++) begin
				taps_o[t*SAMPLE_W +: SAMPLE_W] <= taps_o[(t-1)*SAMPLE_W +: SAMPLE_W];
			end
		end
	end

	// tells the correlators the taps just moved
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			shift_o <= 1'b0;
		end else begin
			shift_o <= stb_i;
		end
	end

	// an unknown strobe would corrupt every lag downstream
	a_stb_known: assert property (
		@(posedge clk) disable iff (!rst_n_i)
		!$isunknown(stb_i)
	) else $error("sample strobe is unknown");

endmodule

//--- baseline_correlator.sv
/*
 * All lags of one baseline.
 * Lag c combines the newest reference sample with partner tap c, and with
 * its complement for the imaginary term. Both terms are added on each shift
 * into saturating signed accumulators, which clear while disabled.
 */
`timescale 1ns/1ps

module baseline_correlator #(
	parameter int NUM_LAGS = 3,
	parameter int SAMPLE_W = 4,
	parameter int ACC_W    = 12
) (
	input  logic                               clk,
	input  logic                               rst_n_i,
	input  logic                               enable_i,
	input  corr_pkg::corr_op_e                 op_i,
	input  logic                               shift_i,
	input  logic [SAMPLE_W-1:0]                ref_i,
	input  logic [NUM_LAGS*SAMPLE_W-1:0]       partner_taps_i,
	output logic signed [NUM_LAGS*ACC_W-1:0]   acc_re_o,
	output logic signed [NUM_LAGS*ACC_W-1:0]   acc_im_o
);

	// wide enough for the full unsigned product plus a sign bit
	localparam int TERM_W = 2*SAMPLE_W + 1;
	localparam logic signed [ACC_W-1:0] ACC_MAX = {1'b0, {(ACC_W-1){1'b1}}};
	localparam logic signed [ACC_W-1:0] ACC_MIN = {1'b1, {(ACC_W-1){1'b0}}};

	function automatic logic signed [TERM_W-1:0] term_f(
		input corr_pkg::corr_op_e  op,
		input logic [SAMPLE_W-1:0] a,
		input logic [SAMPLE_W-1:0] b
	);
		logic signed [TERM_W-1:0] a_ext;
		logic signed [TERM_W-1:0] b_ext;
		a_ext = signed'({{(TERM_W-SAMPLE_W){1'b0}}, a});	// samples are unsigned
		b_ext = signed'({{(TERM_W-SAMPLE_W){1'b0}}, b});
		if (op == corr_pkg::CORR_MULTIPLY) begin
			term_f = a_ext * b_ext;
		end else begin
			term_f = a_ext - b_ext;
		end
	endfunction

	function automatic logic signed [ACC_W-1:0] sat_add(
		input logic signed [ACC_W-1:0]  acc,
		input logic signed [TERM_W-1:0] term
	);
		logic signed [ACC_W:0] sum;
		sum = acc + term;	// one guard bit is enough since ACC_W > TERM_W-1
		if (sum[ACC_W] != sum[ACC_W-1]) begin
			sat_add = sum[ACC_W] ? ACC_MIN : ACC_MAX;
		end else begin
			sat_add = sum[ACC_W-1:0];
		end
	endfunction

	for (genvar c = 0; c < NUM_LAGS; c++) begin : g_lag
		logic [SAMPLE_W-1:0]      partner;
		logic signed [TERM_W-1:0] term_re;
		logic signed [TERM_W-1:0] term_im;
		logic signed [ACC_W-1:0]  acc_re_q;
		logic signed [ACC_W-1:0]  acc_im_q;

		assign partner = partner_taps_i[c*SAMPLE_W +: SAMPLE_W];
		assign term_re = term_f(op_i, ref_i, partner);
		assign term_im = term_f(op_i, ref_i, ~partner);	// complement within sample width

		always_ff @(posedge clk) begin
			if (!rst_n_i || !enable_i) begin
				acc_re_q <= '0;
				acc_im_q <= '0;
			end else if (shift_i) begin
				acc_re_q <= sat_add(acc_re_q, term_re);
				acc_im_q <= sat_add(acc_im_q, term_im);
			end
		end

		assign acc_re_o[c*ACC_W +: ACC_W] = acc_re_q;
		assign acc_im_o[c*ACC_W +: ACC_W] = acc_im_q;
	end

	// the guard bit in sat_add only holds for these widths
	a_widths_ok: assert property (
		@(posedge clk)
		(ACC_W > 2*SAMPLE_W) && (SAMPLE_W <= corr_pkg::SAMPLE_W_MAX)
	) else $error("accumulator too narrow for sample width");

endmodule

//--- corr_readout.sv
/*
 * Accumulator readout port.
 * A read strobe selects one baseline and lag; the pair as it stands at that
 * edge is registered and returned with a one-cycle valid pulse.
 */
`timescale 1ns/1ps

module corr_readout #(
	parameter int NUM_BASELINES = 4,
	parameter int NUM_LAGS      = 3,
	parameter int ACC_W         = 12
) (
	input  logic                                    clk,
	input  logic                                    rst_n_i,
	input  logic                                    rd_stb_i,
	input  logic [corr_pkg::ADDR_W-1:0]             rd_baseline_i,
	input  logic [corr_pkg::ADDR_W-1:0]             rd_lag_i,
	input  logic [NUM_BASELINES*NUM_LAGS*ACC_W-1:0] acc_re_i,
	input  logic [NUM_BASELINES*NUM_LAGS*ACC_W-1:0] acc_im_i,
	output logic                                    rd_valid_o,
	output logic signed [ACC_W-1:0]                 rd_re_o,
	output logic signed [ACC_W-1:0]                 rd_im_o
);

	localparam int IDX_W = 2*corr_pkg::ADDR_W;

	logic             in_range;
	logic [IDX_W-1:0] rd_idx;
	logic [IDX_W-1:0] sel_idx;

	assign in_range = (rd_baseline_i < NUM_BASELINES) && (rd_lag_i < NUM_LAGS);
	assign rd_idx = IDX_W'(rd_baseline_i) * IDX_W'(NUM_LAGS) + IDX_W'(rd_lag_i);
	assign sel_idx = in_range ? rd_idx : '0;	// keep the select inside the vector

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			rd_valid_o <= 1'b0;
		end else begin
			rd_valid_o <= rd_stb_i;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_stb_i) begin
			rd_re_o <= in_range ? acc_re_i[sel_idx*ACC_W +: ACC_W] : '0;
			rd_im_o <= in_range ? acc_im_i[sel_idx*ACC_W +: ACC_W] : '0;
		end
	end

	a_rd_in_range: assert property (
		@(posedge clk) disable iff (!rst_n_i)
		rd_stb_i |-> in_range
	) else $error("read index out of range");

endmodule

//--- correlator_top.sv
/*
 * Intensity correlator top level.
 * One delay line per input channel, one correlator per baseline paired by
 * channel index, and a readout port over the flattened accumulators.
 */
`timescale 1ns/1ps

module correlator_top #(
	parameter int NUM_INPUTS    = 4,
	parameter int NUM_BASELINES = 4,
	parameter int NUM_LAGS      = 3,
	parameter int SAMPLE_W      = 4,
	parameter int ACC_W         = 12
) (
	input  logic                           clk,
	input  logic                           rst_n_i,
	input  logic                           enable_i,
	input  corr_pkg::corr_op_e             op_i,
	input  logic [NUM_INPUTS*SAMPLE_W-1:0] sample_i,
	input  logic                           sample_stb_i,
	input  logic                           rd_stb_i,
	input  logic [corr_pkg::ADDR_W-1:0]    rd_baseline_i,
	input  logic [corr_pkg::ADDR_W-1:0]    rd_lag_i,
	output logic                           rd_valid_o,
	output logic signed [ACC_W-1:0]        rd_re_o,
	output logic signed [ACC_W-1:0]        rd_im_o
);

	localparam int BL_W = NUM_LAGS*ACC_W;	// accumulators of one baseline

	logic [NUM_LAGS*SAMPLE_W-1:0]      taps [NUM_INPUTS];
	logic [NUM_INPUTS-1:0]             shift;
	logic [NUM_BASELINES*BL_W-1:0]     acc_re_all;
	logic [NUM_BASELINES*BL_W-1:0]     acc_im_all;

	for (genvar i = 0; i < NUM_INPUTS; i++) begin : g_line
		sample_delay_line #(
			.NUM_LAGS (NUM_LAGS),
			.SAMPLE_W (SAMPLE_W)
		) delay_line_i (
			.clk      (clk),
			.rst_n_i  (rst_n_i),
			.sample_i (sample_i[i*SAMPLE_W +: SAMPLE_W]),
			.stb_i    (sample_stb_i),
			.taps_o   (taps[i]),
			.shift_o  (shift[i])
		);
	end

	for (genvar k = 0; k < NUM_BASELINES; k++) begin : g_baseline
		localparam int REF_CH  = k % NUM_INPUTS;
		localparam int PART_CH = (k + k/NUM_INPUTS + 1) % NUM_INPUTS;	// order 1 partner

		baseline_correlator #(
			.NUM_LAGS (NUM_LAGS),
			.SAMPLE_W (SAMPLE_W),
			.ACC_W    (ACC_W)
		) baseline_i (
			.clk            (clk),
			.rst_n_i        (rst_n_i),
			.enable_i       (enable_i),
			.op_i           (op_i),
			.shift_i        (shift[0]),
			.ref_i          (taps[REF_CH][SAMPLE_W-1:0]),
			.partner_taps_i (taps[PART_CH]),
			.acc_re_o       (acc_re_all[k*BL_W +: BL_W]),
			.acc_im_o       (acc_im_all[k*BL_W +: BL_W])
		);
	end

	corr_readout #(
		.NUM_BASELINES (NUM_BASELINES),
		.NUM_LAGS      (NUM_LAGS),
		.ACC_W         (ACC_W)
	) readout_i (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.rd_stb_i      (rd_stb_i),
		.rd_baseline_i (rd_baseline_i),
		.rd_lag_i      (rd_lag_i),
		.acc_re_i      (acc_re_all),
		.acc_im_i      (acc_im_all),
		.rd_valid_o    (rd_valid_o),
		.rd_re_o       (rd_re_o),
		.rd_im_o       (rd_im_o)
	);

endmodule

//--- correlator_tb.sv
/*
 * Testbench for the intensity correlator top level.
 * Applies a table of sample rows, keeps a reference model of taps and
 * accumulators, and reads back every accumulator pair after flagged rows.
 */
`timescale 1ns/1ps

module correlator_tb;

	localparam int NUM_INPUTS    = 4;
	localparam int NUM_BASELINES = 4;
	localparam int NUM_LAGS      = 3;
	localparam int SAMPLE_W      = 4;
	localparam int ACC_W         = 12;
	localparam int NUM_READS     = NUM_BASELINES*NUM_LAGS;
	localparam int SAMPLE_MAX    = (1 << SAMPLE_W) - 1;
	localparam int ACC_HI        = (1 << (ACC_W-1)) - 1;
	localparam int ACC_LO        = -(1 << (ACC_W-1));

	typedef struct packed {
		logic                           en;
		corr_pkg::corr_op_e             op;
		logic [NUM_INPUTS*SAMPLE_W-1:0] samples;	// channel 0 in the low nibble
		logic                           rd;
	} row_t;

	logic clk = 1'b0;
	logic rst_n_i;
	logic enable_i;
	corr_pkg::corr_op_e op_i;
	logic [NUM_INPUTS*SAMPLE_W-1:0] sample_i;
	logic sample_stb_i;
	logic rd_stb_i;
	logic [corr_pkg::ADDR_W-1:0] rd_baseline_i;
	logic [corr_pkg::ADDR_W-1:0] rd_lag_i;
	logic rd_valid_o;
	logic signed [ACC_W-1:0] rd_re_o;
	logic signed [ACC_W-1:0] rd_im_o;

	row_t rows [$];
	int model_taps [NUM_INPUTS][NUM_LAGS];
	int model_re [NUM_BASELINES][NUM_LAGS];
	int model_im [NUM_BASELINES][NUM_LAGS];
	int cycle_count = 0;
	int cycle_limit = 0;

	correlator_top #(
		.NUM_INPUTS    (NUM_INPUTS),
		.NUM_BASELINES (NUM_BASELINES),
		.NUM_LAGS      (NUM_LAGS),
		.SAMPLE_W      (SAMPLE_W),
		.ACC_W         (ACC_W)
	) correlator_top_i (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.enable_i      (enable_i),
		.op_i          (op_i),
		.sample_i      (sample_i),
		.sample_stb_i  (sample_stb_i),
		.rd_stb_i      (rd_stb_i),
		.rd_baseline_i (rd_baseline_i),
		.rd_lag_i      (rd_lag_i),
		.rd_valid_o    (rd_valid_o),
		.rd_re_o       (rd_re_o),
		.rd_im_o       (rd_im_o)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			report_failure($sformatf("simulation timed out after %0d cycles", cycle_count));
		end
	end

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("=== FAIL ===");
		$fatal(1, "stopping on first error");
	endtask

	task automatic check_acc(
		input logic signed [ACC_W-1:0] got_re,
		input logic signed [ACC_W-1:0] got_im,
		input logic signed [ACC_W-1:0] exp_re,
		input logic signed [ACC_W-1:0] exp_im,
		input int bl,
		input int lag
	);
		if (got_re !== exp_re || got_im !== exp_im) begin
			report_failure($sformatf(
				"CHECK FAILED @ %0t: baseline %0d lag %0d re %0d/%0d im %0d/%0d (got/exp)",
				$time, bl, lag, got_re, exp_re, got_im, exp_im));
		end
	endtask

	task automatic check_valid(input logic got, input logic expected);
		if (got !== expected) begin
			report_failure($sformatf("CHECK FAILED @ %0t: rd_valid_o %b, expected %b",
				$time, got, expected));
		end
	endtask

	function automatic int combine(input corr_pkg::corr_op_e op, input int a, input int b);
		return (op == corr_pkg::CORR_MULTIPLY) ? a * b : a - b;
	endfunction

	function automatic int clamp(input int v);
		return (v > ACC_HI) ? ACC_HI : ((v < ACC_LO) ? ACC_LO : v);
	endfunction

	task automatic add_row(input logic en, input corr_pkg::corr_op_e op,
			input logic [NUM_INPUTS*SAMPLE_W-1:0] smp, input logic rd);
		row_t r;
		r.en = en;
		r.op = op;
		r.samples = smp;
		r.rd = rd;
		rows.push_back(r);
	endtask

	task automatic build_table();
		int unsigned rnd;
		add_row(1'b1, corr_pkg::CORR_MULTIPLY, 16'h4321, 1'b0);
		add_row(1'b1, corr_pkg::CORR_MULTIPLY, 16'h1234, 1'b0);
		add_row(1'b1, corr_pkg::CORR_MULTIPLY, 16'h5a3c, 1'b1);
		add_row(1'b1, corr_pkg::CORR_MULTIPLY, 16'h0f70, 1'b1);
		add_row(1'b1, corr_pkg::CORR_SUBTRACT, 16'h0000, 1'b0);	// newest zero, so terms go negative
		add_row(1'b1, corr_pkg::CORR_SUBTRACT, 16'h0000, 1'b1);
		add_row(1'b1, corr_pkg::CORR_SUBTRACT, 16'h8421, 1'b1);
		for (int i = 0; i < 13; i++) begin
			add_row(1'b1, corr_pkg::CORR_MULTIPLY, 16'hffff, i >= 11);
		end
		add_row(1'b1, corr_pkg::CORR_SUBTRACT, 16'h0000, 1'b1);
		add_row(1'b1, corr_pkg::CORR_SUBTRACT, 16'h3333, 1'b1);
		add_row(1'b0, corr_pkg::CORR_MULTIPLY, 16'h1111, 1'b1);	// clears everything
		add_row(1'b1, corr_pkg::CORR_MULTIPLY, 16'h2222, 1'b1);
		for (int i = 0; i < 6; i++) begin
			rnd = $urandom;
			add_row(1'b1, corr_pkg::corr_op_e'(rnd[16]), rnd[15:0], 1'b1);
		end
	endtask

	task automatic model_step(input row_t r);
		int ref_s;
		int part;
		for (int ch = 0; ch < NUM_INPUTS; ch++) begin
			for (int t = NUM_LAGS-1; t > 0; t--) begin
				model_taps[ch][t] = model_taps[ch][t-1];
			end
			model_taps[ch][0] = r.samples[ch*SAMPLE_W +: SAMPLE_W];
		end
		for (int k = 0; k < NUM_BASELINES; k++) begin
			for (int c = 0; c < NUM_LAGS; c++) begin
				ref_s = model_taps[k % NUM_INPUTS][0];
				part = model_taps[(k + k/NUM_INPUTS + 1) % NUM_INPUTS][c];
				if (!r.en) begin
					model_re[k][c] = 0;
					model_im[k][c] = 0;
				end else begin
					model_re[k][c] = clamp(model_re[k][c] + combine(r.op, ref_s, part));
					model_im[k][c] = clamp(model_im[k][c] +
						combine(r.op, ref_s, SAMPLE_MAX - part));
				end
			end
		end
	endtask

	task automatic apply_row(input row_t r);
		enable_i = r.en;
		op_i = r.op;
		sample_i = r.samples;
		sample_stb_i = 1'b1;
		check_valid(rd_valid_o, 1'b0);
		@(negedge clk);
		sample_stb_i = 1'b0;
		@(negedge clk);	// accumulators have taken the shift by now
		model_step(r);
	endtask

	// back-to-back reads, each checked one cycle after its strobe
	task automatic read_all();
		for (int n = 0; n < NUM_READS; n++) begin
			rd_stb_i = 1'b1;
			rd_baseline_i = n / NUM_LAGS;
			rd_lag_i = n % NUM_LAGS;
			@(negedge clk);
			check_valid(rd_valid_o, 1'b1);
			check_acc(rd_re_o, rd_im_o, model_re[n/NUM_LAGS][n%NUM_LAGS],
				model_im[n/NUM_LAGS][n%NUM_LAGS], n / NUM_LAGS, n % NUM_LAGS);
		end
		rd_stb_i = 1'b0;
		@(negedge clk);
		check_valid(rd_valid_o, 1'b0);
	endtask

	initial begin
		int unsigned seed_ret;
		seed_ret = $urandom(32'hd1ea_ca6e);
		rst_n_i = 1'b0;
		enable_i = 1'b0;
		op_i = corr_pkg::CORR_MULTIPLY;
		sample_i = '0;
		sample_stb_i = 1'b0;
		rd_stb_i = 1'b0;
		rd_baseline_i = '0;
		rd_lag_i = '0;
		for (int i = 0; i < NUM_INPUTS; i++) begin
			for (int t = 0; t < NUM_LAGS; t++) begin
				model_taps[i][t] = 0;
			end
		end
		for (int k = 0; k < NUM_BASELINES; k++) begin
			for (int c = 0; c < NUM_LAGS; c++) begin
				model_re[k][c] = 0;
				model_im[k][c] = 0;
			end
		end
		build_table();
		cycle_limit = rows.size() * (NUM_READS + 4) + 50;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n_i = 1'b1;
		@(negedge clk);
		check_valid(rd_valid_o, 1'b0);
		read_all();	// everything zero out of reset
		foreach (rows[i]) begin
			apply_row(rows[i]);
			if (rows[i].rd) begin
				read_all();
			end
		end
		$display("=== PASS ===");
		$finish;
	end

endmodule

//--- correlator.f
corr_pkg.sv
sample_delay_line.sv
baseline_correlator.sv
corr_readout.sv
correlator_top.sv
correlator_tb.sv

//--- Bender.yml
package:
  name: correlator

sources:
  - corr_pkg.sv
  - sample_delay_line.sv
  - baseline_correlator.sv
  - corr_readout.sv
  - correlator_top.sv
  - target: test
    files:
      - correlator_tb.sv
